// File: Makefile
TOP := conv_layer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f conv_layer_top.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -f conv_layer_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: conv_layer_top.f
hdl/conv_pkg.sv
hdl/scratch_mem.sv
hdl/mem_arbiter.sv
hdl/layer_sequencer.sv
hdl/patch_fetcher.sv
hdl/mac_accumulator.sv
hdl/result_writer.sv
hdl/conv_layer_top.sv
dv/conv_layer_tb.sv

// File: dv/conv_layer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module conv_layer_tb;

    localparam int NUM_LAYERS   = 6;
    localparam int CLK_PERIOD   = 20;
    localparam int LAYER_CYCLES = 20000;
    localparam int MAP_WORDS    = conv_pkg::MAP_SIZE * conv_pkg::MAP_SIZE;
    localparam int TAPS         = conv_pkg::KER_SIZE * conv_pkg::KER_SIZE;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 start;
    conv_pkg::layer_cfg_t cfg;
    logic                 busy;
    logic                 done;
    logic                 host_req;
    conv_pkg::mem_req_t   host_cmd;
    logic                 host_ack;
    conv_pkg::mem_word_t  host_rdata;

    logic [31:0] rng_state = 32'd92000;

    // model copy of what the host loaded
    int                  feat [conv_pkg::CIN_MAX][MAP_WORDS];
    int                  wgt [conv_pkg::COUT_MAX][conv_pkg::CIN_MAX][TAPS];
    conv_pkg::mem_word_t out_init [conv_pkg::COUT_MAX][4];

    conv_layer_top i_conv_layer_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .busy       (busy),
        .done       (done),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // signed byte, or only the two extremes to force saturation
    function automatic int pick_value(input logic extreme);
        logic [31:0] r;
        r = next_rand();
        if (extreme)
            return r[0] ? 127 : -128;
        return int'($signed(r[7:0]));
    endfunction

    function automatic conv_pkg::mem_word_t clamp16(input int v);
        if (v > 32767)
            return 16'h7fff;
        if (v < -32768)
            return 16'h8000;
        return conv_pkg::mem_word_t'(v);
    endfunction

    function automatic conv_pkg::mem_word_t expected_out(input conv_pkg::layer_cfg_t c,
                                                         input int o, input int p);
        int sum;
        int row;
        int col;
        sum = 0;
        row = p / conv_pkg::OUT_SIZE;
        col = p % conv_pkg::OUT_SIZE;
        // channels beyond num_cout are never written
        if (o >= int'(c.num_cout))
            return out_init[o][p];
        for (int i = 0; i < int'(c.num_cin); i++)
            for (int kr = 0; kr < conv_pkg::KER_SIZE; kr++)
                for (int kc = 0; kc < conv_pkg::KER_SIZE; kc++)
                    sum += feat[i][(row + kr) * conv_pkg::MAP_SIZE + col + kc]
                        * wgt[o][i][kr * conv_pkg::KER_SIZE + kc];
        return clamp16(sum);
    endfunction

    task automatic check_word(input string name, input conv_pkg::mem_word_t got,
                              input conv_pkg::mem_word_t exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // one four-phase transfer on the host port
    task automatic host_access(input conv_pkg::mem_req_t c, output conv_pkg::mem_word_t rd);
        @(posedge clk);
        host_req <= 1'b1;
        host_cmd <= c;
        do
            @(negedge clk);
        while (!host_ack);
        rd = host_rdata;
        @(posedge clk);
        host_req <= 1'b0;
        do
            @(negedge clk);
        while (host_ack);
    endtask

    task automatic mem_write(input int addr, input conv_pkg::mem_word_t data);
        conv_pkg::mem_req_t  c;
        conv_pkg::mem_word_t unused;
        c.we    = 1'b1;
        c.addr  = conv_pkg::mem_addr_t'(addr);
        c.wdata = data;
        host_access(c, unused);
    endtask

    task automatic mem_read(input int addr, output conv_pkg::mem_word_t data);
        conv_pkg::mem_req_t c;
        c.we    = 1'b0;
        c.addr  = conv_pkg::mem_addr_t'(addr);
        c.wdata = '0;
        host_access(c, data);
    endtask

    task automatic load_layer(input logic extreme);
        logic [31:0] r;
        for (int i = 0; i < conv_pkg::CIN_MAX; i++)
            for (int n = 0; n < MAP_WORDS; n++)
            begin
                feat[i][n] = pick_value(extreme);
                mem_write(conv_pkg::FEAT_BASE + i * MAP_WORDS + n,
                          conv_pkg::mem_word_t'(feat[i][n]));
            end
        for (int o = 0; o < conv_pkg::COUT_MAX; o++)
            for (int i = 0; i < conv_pkg::CIN_MAX; i++)
                for (int k = 0; k < TAPS; k++)
                begin
                    wgt[o][i][k] = pick_value(extreme);
                    mem_write(conv_pkg::WGT_BASE + (o * conv_pkg::CIN_MAX + i) * TAPS + k,
                              conv_pkg::mem_word_t'(wgt[o][i][k]));
                end
        // marker values in the whole output region
        for (int o = 0; o < conv_pkg::COUT_MAX; o++)
            for (int p = 0; p < 4; p++)
            begin
                r = next_rand();
                out_init[o][p] = r[15:0];
                mem_write(conv_pkg::OUT_BASE + o * 4 + p, out_init[o][p]);
            end
    endtask

    task automatic run_layer(input conv_pkg::layer_cfg_t c);
        conv_pkg::layer_cfg_t other;
        int                   n;
        logic                 finished;
        other.num_cin  = (c.num_cin == 3'd4) ? 3'd1 : 3'd4;
        other.num_cout = (c.num_cout == 3'd4) ? 3'd1 : 3'd4;
        n = 0;
        finished = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        cfg   <= c;
        while (!finished)
        begin
            @(posedge clk);
            // a second start while busy is ignored
            start <= (n == 8);
            cfg   <= (n == 8) ? other : c;
            @(negedge clk);
            if (done)
            begin
                check_flag("busy", busy, 1'b0);
                finished = 1'b1;
            end
            else
                check_flag("busy", busy, 1'b1);
            n++;
        end
        // done lasts a single cycle
        @(negedge clk);
        check_flag("done", done, 1'b0);
    endtask

    task automatic check_outputs(input conv_pkg::layer_cfg_t c);
        conv_pkg::mem_word_t rd;
        int                  addr;
        for (int o = 0; o < conv_pkg::COUT_MAX; o++)
            for (int p = 0; p < 4; p++)
            begin
                addr = conv_pkg::OUT_BASE + o * 4 + p;
                mem_read(addr, rd);
                check_word($sformatf("mem[%0d]", addr), rd, expected_out(c, o, p));
            end
    endtask

    initial
    begin
        conv_pkg::mem_word_t  rd;
        conv_pkg::layer_cfg_t lc;
        logic [31:0]          r;
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg      = '0;
        host_req = 1'b0;
        host_cmd = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("host_ack", host_ack, 1'b0);

        // plain host write and read back
        repeat (8)
        begin
            r = next_rand();
            mem_write(int'(r[7:0]), r[23:8]);
            mem_read(int'(r[7:0]), rd);
            check_word($sformatf("mem[%0d]", r[7:0]), rd, r[23:8]);
        end

        for (int n = 0; n < NUM_LAYERS; n++)
        begin
            r = next_rand();
            lc.num_cout = 3'(r[1:0]) + 3'd1;
            lc.num_cin  = (n == 0) ? 3'd1 : 3'(r[3:2]) + 3'd1;
            // last layer is full size with extreme data
            if (n == NUM_LAYERS - 1)
            begin
                lc.num_cin  = 3'd4;
                lc.num_cout = 3'd4;
            end
            load_layer(n == NUM_LAYERS - 1);
            run_layer(lc);
            check_outputs(lc);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial
    begin
        #(NUM_LAYERS * LAYER_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: hdl/conv_layer_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_layer_top
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire conv_pkg::layer_cfg_t cfg,
    output logic                      busy,
    output logic                      done,
    input  wire logic                 host_req,
    input  wire conv_pkg::mem_req_t   host_cmd,
    output logic                      host_ack,
    output conv_pkg::mem_word_t       host_rdata
);

    // arbiter slots: 0 host, 1 fetcher, 2 writer
    logic [2:0]          req;
    logic [2:0]          ack;
    conv_pkg::mem_req_t  cmd [3];
    conv_pkg::mem_word_t rdata;

    logic                mem_en;
    logic                mem_we;
    conv_pkg::mem_addr_t mem_addr;
    conv_pkg::mem_word_t mem_wdata;
    conv_pkg::mem_word_t mem_rdata;

    logic                fetch_start;
    logic                fetch_done;
    logic                acc_clear;
    logic                write_start;
    logic                write_done;
    conv_pkg::chan_t     cin_idx;
    conv_pkg::chan_t     cout_idx;
    logic                mac_valid;
    conv_pkg::mac_op_t   mac_op;
    conv_pkg::acc_t      acc [4];

    assign req[0]     = host_req;
    assign cmd[0]     = host_cmd;
    assign host_ack   = ack[0];
    assign host_rdata = rdata;

    layer_sequencer i_layer_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .busy        (busy),
        .done        (done),
        .fetch_start (fetch_start),
        .cin_idx     (cin_idx),
        .cout_idx    (cout_idx),
        .fetch_done  (fetch_done),
        .acc_clear   (acc_clear),
        .write_start (write_start),
        .write_done  (write_done)
    );

    patch_fetcher i_patch_fetcher (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (fetch_start),
        .cin_idx   (cin_idx),
        .cout_idx  (cout_idx),
        .done      (fetch_done),
        .req       (req[1]),
        .cmd       (cmd[1]),
        .ack       (ack[1]),
        .rdata     (rdata),
        .mac_valid (mac_valid),
        .mac_op    (mac_op)
    );

    mac_accumulator i_mac_accumulator (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (acc_clear),
        .mac_valid (mac_valid),
        .mac_op    (mac_op),
        .acc       (acc)
    );

    result_writer i_result_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (write_start),
        .cout_idx (cout_idx),
        .acc      (acc),
        .done     (write_done),
        .req      (req[2]),
        .cmd      (cmd[2]),
        .ack      (ack[2])
    );

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .cmd       (cmd),
        .ack       (ack),
        .rdata     (rdata),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    scratch_mem i_scratch_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // feature map and kernel geometry
    localparam int MAP_SIZE = 4;
    localparam int KER_SIZE = 3;
    localparam int OUT_SIZE = 2;
    localparam int CIN_MAX  = 4;
    localparam int COUT_MAX = 4;

    // scratch memory map
    localparam int MEM_DEPTH = 256;
    localparam int FEAT_BASE = 0;
    localparam int WGT_BASE  = 64;
    localparam int OUT_BASE  = 208;

    // signed 16-bit output range
    localparam int SAT_MAX = 32767;
    localparam int SAT_MIN = -32768;

    typedef logic [7:0]         mem_addr_t;
    typedef logic [15:0]        mem_word_t;
    typedef logic signed [21:0] acc_t;
    typedef logic [1:0]         chan_t;

    typedef struct packed {
        logic      we;
        mem_addr_t addr;
        mem_word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic [2:0] num_cin;
        logic [2:0] num_cout;
    } layer_cfg_t;

    typedef struct packed {
        logic [7:0] pixel;
        logic [7:0] weight;
        logic [1:0] out_idx;
    } mac_op_t;

endpackage

`default_nettype wire

// File: hdl/layer_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module layer_sequencer
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire conv_pkg::layer_cfg_t cfg,
    output logic                      busy,
    output logic                      done,
    output logic                      fetch_start,
    output conv_pkg::chan_t           cin_idx,
    output conv_pkg::chan_t           cout_idx,
    input  wire logic                 fetch_done,
    output logic                      acc_clear,
    output logic                      write_start,
    input  wire logic                 write_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHAN_LOAD,
        S_COUNT_IN,
        S_CONV,
        S_COUNT_OUT,
        S_WRITE
    } state_t;

    state_t               state;
    conv_pkg::layer_cfg_t cfg_q;
    logic                 last_cin;
    logic                 last_cout;

    assign last_cin  = ({1'b0, cin_idx} + 3'd1) >= cfg_q.num_cin;
    assign last_cout = ({1'b0, cout_idx} + 3'd1) >= cfg_q.num_cout;

    assign busy      = (state != S_IDLE);
    assign acc_clear = (state == S_CHAN_LOAD);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= S_IDLE;
            cfg_q       <= '0;
            cin_idx     <= '0;
            cout_idx    <= '0;
            done        <= 1'b0;
            fetch_start <= 1'b0;
            write_start <= 1'b0;
        end
        else
        begin
            done        <= 1'b0;
            fetch_start <= 1'b0;
            write_start <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        cfg_q    <= cfg;
                        cout_idx <= '0;
                        state    <= S_CHAN_LOAD;
                    end
                end
                S_CHAN_LOAD:
                begin
                    // accumulators clear here, first input channel follows
                    cin_idx     <= '0;
                    fetch_start <= 1'b1;
                    state       <= S_CONV;
                end
                S_CONV:
                begin
                    if (fetch_done)
                        state <= S_COUNT_IN;
                end
                S_COUNT_IN:
                begin
                    if (last_cin)
                    begin
                        write_start <= 1'b1;
                        state       <= S_WRITE;
                    end
                    else
                    begin
                        cin_idx     <= cin_idx + 2'd1;
                        fetch_start <= 1'b1;
                        state       <= S_CONV;
                    end
                end
                S_WRITE:
                begin
                    if (write_done)
                        state <= S_COUNT_OUT;
                end
                S_COUNT_OUT:
                begin
                    if (last_cout)
                    begin
                        // busy drops in the same cycle as done
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                    else
                    begin
                        cout_idx <= cout_idx + 2'd1;
                        state    <= S_CHAN_LOAD;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // the fetcher only finishes work that was started from the convolve state
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done |-> state == S_CONV);

endmodule

`default_nettype wire

// File: hdl/mac_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module mac_accumulator
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              clear,
    input  wire logic              mac_valid,
    input  wire conv_pkg::mac_op_t mac_op,
    output conv_pkg::acc_t         acc [4]
);

    logic signed [15:0] product;

    assign product = $signed(mac_op.pixel) * $signed(mac_op.weight);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 4; i++)
                acc[i] <= '0;
        end
        else if (clear)
        begin
            for (int i = 0; i < 4; i++)
                acc[i] <= '0;
        end
        else if (mac_valid)
        begin
            // product sign-extends into the wider sum
            acc[mac_op.out_idx] <= acc[mac_op.out_idx] + conv_pkg::acc_t'(product);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [2:0]         req,
    input  wire conv_pkg::mem_req_t cmd [3],
    output logic [2:0]              ack,
    output conv_pkg::mem_word_t     rdata,
    output logic                    mem_en,
    output logic                    mem_we,
    output conv_pkg::mem_addr_t     mem_addr,
    output conv_pkg::mem_word_t     mem_wdata,
    input  wire conv_pkg::mem_word_t mem_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_ACK
    } state_t;

    state_t     state;
    logic [1:0] ptr;
    logic [1:0] grant;
    logic [1:0] winner;
    logic       found;

    // first requester at or after the pointer wins
    always_comb
    begin
        winner = ptr;
        found  = 1'b0;
        for (int k = 0; k < 3; k++)
        begin
            int idx;
            idx = int'(ptr) + k;
            if (idx >= 3)
                idx = idx - 3;
            if (!found && req[idx])
            begin
                found  = 1'b1;
                winner = 2'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
            ptr   <= '0;
            grant <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (found)
                    begin
                        grant <= winner;
                        ptr   <= (winner == 2'd2) ? 2'd0 : winner + 2'd1;
                        state <= S_ACCESS;
                    end
                end
                S_ACCESS:
                begin
                    state <= S_ACK;
                end
                S_ACK:
                begin
                    // hold until the requester releases
                    if (!req[grant])
                        state <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign mem_en    = (state == S_ACCESS);
    assign mem_we    = mem_en && cmd[grant].we;
    assign mem_addr  = cmd[grant].addr;
    assign mem_wdata = cmd[grant].wdata;
    assign ack       = (state == S_ACK) ? (3'b001 << grant) : 3'b000;
    // memory output holds between accesses
    assign rdata     = mem_rdata;

    for (genvar i = 0; i < 3; i++)
    begin : g_ack_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(ack[i]) |-> req[i]);

        // a new request only once the previous ack is low
        assert property (@(posedge clk) disable iff (!rst_n)
            $rose(req[i]) |-> !ack[i]);
    end

endmodule

`default_nettype wire

// File: hdl/patch_fetcher.sv
`timescale 1ns/10ps
`default_nettype none

module patch_fetcher
(
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire conv_pkg::chan_t     cin_idx,
    input  wire conv_pkg::chan_t     cout_idx,
    output logic                     done,
    output logic                     req,
    output conv_pkg::mem_req_t       cmd,
    input  wire logic                ack,
    input  wire conv_pkg::mem_word_t rdata,
    output logic                     mac_valid,
    output conv_pkg::mac_op_t        mac_op
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FEAT_REQ,
        S_FEAT_REL,
        S_WGT_REQ,
        S_WGT_REL
    } state_t;

    state_t              state;
    conv_pkg::chan_t     cin_q;
    conv_pkg::chan_t     cout_q;
    logic [1:0]          pos;
    logic [1:0]          kr;
    logic [1:0]          kc;
    logic [7:0]          pixel_q;
    logic                last_tap;
    conv_pkg::mem_addr_t feat_addr;
    conv_pkg::mem_addr_t wgt_addr;

    // pos is row*2 + col of the output
    assign feat_addr = conv_pkg::mem_addr_t'(conv_pkg::FEAT_BASE
        + int'(cin_q) * conv_pkg::MAP_SIZE * conv_pkg::MAP_SIZE
        + (int'(pos[1]) + int'(kr)) * conv_pkg::MAP_SIZE
        + int'(pos[0]) + int'(kc));
    assign wgt_addr  = conv_pkg::mem_addr_t'(conv_pkg::WGT_BASE
        + (int'(cout_q) * conv_pkg::CIN_MAX + int'(cin_q)) * conv_pkg::KER_SIZE
        * conv_pkg::KER_SIZE + int'(kr) * conv_pkg::KER_SIZE + int'(kc));

    assign last_tap = (pos == 2'(conv_pkg::OUT_SIZE * conv_pkg::OUT_SIZE - 1))
        && (kr == 2'(conv_pkg::KER_SIZE - 1)) && (kc == 2'(conv_pkg::KER_SIZE - 1));

    assign req       = (state == S_FEAT_REQ) || (state == S_WGT_REQ);
    assign cmd.we    = 1'b0;
    assign cmd.addr  = (state == S_FEAT_REQ) ? feat_addr : wgt_addr;
    assign cmd.wdata = '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= S_IDLE;
            done      <= 1'b0;
            mac_valid <= 1'b0;
            cin_q     <= '0;
            cout_q    <= '0;
            pos       <= '0;
            kr        <= '0;
            kc        <= '0;
        end
        else
        begin
            done      <= 1'b0;
            mac_valid <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        cin_q  <= cin_idx;
                        cout_q <= cout_idx;
                        pos    <= '0;
                        kr     <= '0;
                        kc     <= '0;
                        state  <= S_FEAT_REQ;
                    end
                end
                S_FEAT_REQ:
                begin
                    if (ack)
                        state <= S_FEAT_REL;
                end
                S_FEAT_REL:
                begin
                    if (!ack)
                        state <= S_WGT_REQ;
                end
                S_WGT_REQ:
                begin
                    if (ack)
                    begin
                        mac_valid <= 1'b1;
                        state     <= S_WGT_REL;
                    end
                end
                S_WGT_REL:
                begin
                    if (!ack)
                    begin
                        if (last_tap)
                        begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                        else
                        begin
                            // column, then row, then output position
                            if (kc == 2'(conv_pkg::KER_SIZE - 1))
                            begin
                                kc <= '0;
                                if (kr == 2'(conv_pkg::KER_SIZE - 1))
                                begin
                                    kr  <= '0;
                                    pos <= pos + 2'd1;
                                end
                                else
                                    kr <= kr + 2'd1;
                            end
                            else
                                kc <= kc + 2'd1;
                            state <= S_FEAT_REQ;
                        end
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_FEAT_REQ && ack)
            pixel_q <= rdata[7:0];
        if (state == S_WGT_REQ && ack)
        begin
            mac_op.pixel   <= pixel_q;
            mac_op.weight  <= rdata[7:0];
            mac_op.out_idx <= pos;
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_writer.sv
`timescale 1ns/10ps
`default_nettype none

module result_writer
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            start,
    input  wire conv_pkg::chan_t cout_idx,
    input  wire conv_pkg::acc_t  acc [4],
    output logic                 done,
    output logic                 req,
    output conv_pkg::mem_req_t   cmd,
    input  wire logic            ack
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_REL
    } state_t;

    state_t          state;
    conv_pkg::chan_t cout_q;
    logic [1:0]      idx;

    function automatic conv_pkg::mem_word_t saturate(conv_pkg::acc_t v);
        if (v > conv_pkg::SAT_MAX)
            return 16'h7fff;
        else if (v < conv_pkg::SAT_MIN)
            return 16'h8000;
        return v[15:0];
    endfunction

    assign req       = (state == S_REQ);
    assign cmd.we    = 1'b1;
    assign cmd.addr  = conv_pkg::mem_addr_t'(conv_pkg::OUT_BASE
        + int'(cout_q) * conv_pkg::OUT_SIZE * conv_pkg::OUT_SIZE + int'(idx));
    assign cmd.wdata = saturate(acc[idx]);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= S_IDLE;
            done   <= 1'b0;
            cout_q <= '0;
            idx    <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        cout_q <= cout_idx;
                        idx    <= '0;
                        state  <= S_REQ;
                    end
                end
                S_REQ:
                begin
                    if (ack)
                        state <= S_REL;
                end
                S_REL:
                begin
                    // next word only once ack has dropped
                    if (!ack)
                    begin
                        if (idx == 2'd3)
                        begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                        else
                        begin
                            idx   <= idx + 2'd1;
                            state <= S_REQ;
                        end
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/scratch_mem.sv
`timescale 1ns/10ps
`default_nettype none

module scratch_mem
(
    input  wire logic                clk,
    input  wire logic                en,
    input  wire logic                we,
    input  wire conv_pkg::mem_addr_t addr,
    input  wire conv_pkg::mem_word_t wdata,
    output conv_pkg::mem_word_t      rdata
);

    conv_pkg::mem_word_t mem [conv_pkg::MEM_DEPTH];

    // read data registered, held while not enabled
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire
